// File: Bender.yml
package:
  name: eflash_row_driver

sources:
  - files:
      - logic/eflash_pkg.sv
      - logic/wl_decoder.sv
      - logic/array_sequencer.sv
      - logic/row_drive_merge.sv
      - logic/eflash_row_driver.sv
  - target: test
    files:
      - dv/eflash_row_driver_checker.sv
      - dv/tb_eflash_row_driver.sv

// File: compile.f
logic/eflash_pkg.sv
logic/wl_decoder.sv
logic/array_sequencer.sv
logic/row_drive_merge.sv
logic/eflash_row_driver.sv
dv/eflash_row_driver_checker.sv
dv/tb_eflash_row_driver.sv

// File: dv/eflash_row_driver_checker.sv
// concurrent checks on the registered drive outputs, bound into the row driver top

`timescale 1ns/1ps

module eflash_row_driver_checker (
    input logic                     clk_i,
    input logic                     rst_ni,
    input eflash_pkg::hvs_drive_t   hvs_i,
    input eflash_pkg::array_drive_t array_i
);

    // only one sense path at a time
    adc_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(array_i.adc_en1 && array_i.adc_en2))
    else $error("adc_en1 and adc_en2 are high together");

    // parallel read is the only case with several word lines
    wl_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (array_i.rsel != 2'd2) |-> $onehot0(hvs_i.wl_sel))
    else $error("more than one word line selected outside parallel read");

    idle_after_reset_a: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (hvs_i == eflash_pkg::HVS_IDLE &&
                           array_i == eflash_pkg::ARRAY_IDLE))
    else $error("outputs not idle in the first cycle after reset");

    vpass_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (hvs_i.wl_sel == '0) |-> (hvs_i.vpass_en == '1))
    else $error("pass gates not all enabled while no word line is selected");

endmodule

bind eflash_row_driver eflash_row_driver_checker u_checker (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .hvs_i   (hvs_o),
    .array_i (array_o)
);

// File: dv/eflash_row_driver_stim.txt
# en mode exec_cnt row col, then expected hvs_mode wl_sel vpass_en duml csl bsel csel adc1 adc2 qdac rsel
# all hex; the expected drive appears one cycle after its command
0 1 0 05 000 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0
1 0 0 10 001 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0
1 5 3 22 002 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0
1 6 8 33 003 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0
1 7 1 44 000 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0
0 3 8 05 001 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0
1 1 0 00 000 0 1 ffffffffffffffffffffffffffffffff 00 00 ffffffff 01 0 0 ff 0
1 1 0 13 000 0 80000 ffffffffffffffffffffffffffffffff 00 00 ffffffff 02 0 0 ff 0
1 1 0 2a 000 0 40000000000 ffffffffffffffffffffffffffffffff 00 00 ffffffff 04 0 0 ff 0
1 2 0 07 001 1 80 80 00 ff 02020202 01 0 0 ff 0
1 2 0 3c 1ff 1 1000000000000000 1000000000000000 00 ff 08080808 08 0 0 ff 0
1 3 8 25 002 2 2000000000 2000000000 04 00 04040404 00 0 0 ff 1
1 3 5 25 002 2 2000000000 2000000000 04 00 04040404 00 0 0 ff 1
1 3 4 25 002 2 2000000000 2000000000 00 00 04040404 00 0 0 ff 1
1 3 2 25 002 2 2000000000 2000000000 00 00 00000000 04 0 0 ff 1
1 3 0 25 002 2 2000000000 2000000000 00 00 00000000 04 1 0 ff 1
1 3 c 25 002 2 2000000000 2000000000 00 00 00000000 00 0 0 ff 1
1 4 b 73 001 2 80008000800080008000800080008 80008000800080008000800080008 ff 00 02020202 00 0 0 ff 2
1 4 6 73 001 2 80008000800080008000800080008 80008000800080008000800080008 ff 00 02020202 00 0 0 ff 2
1 4 5 73 001 2 80008000800080008000800080008 80008000800080008000800080008 00 00 0 ff 0 0 ff 2
1 4 4 73 001 2 80008000800080008000800080008 80008000800080008000800080008 00 00 0 ff 1 0 ff 2
1 4 3 73 001 2 80008000800080008000800080008 80008000800080008000800080008 00 00 0 ff 1 0 00 2
1 4 2 73 001 2 80008000800080008000800080008 80008000800080008000800080008 00 00 0 ff 0 0 00 2
1 4 0 73 001 2 80008000800080008000800080008 80008000800080008000800080008 00 00 0 ff 0 1 00 2
1 4 f 73 001 2 80008000800080008000800080008 80008000800080008000800080008 00 00 0 00 0 0 ff 2
1 2 0 51 002 1 200000000000000000000 200000000000000000000 00 ff 04040404 20 0 0 ff 0
0 3 0 51 002 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0
1 3 1 18 003 2 1000000 1000000 00 00 00000000 02 1 0 ff 1
1 1 0 64 000 0 10000000000000000000000000 ffffffffffffffffffffffffffffffff 00 00 ffffffff 40 0 0 ff 0
1 4 5 2c 000 2 10001000100010001000100010001000 10001000100010001000100010001000 00 00 0 ff 0 0 ff 2
1 3 9 40 000 2 10000000000000000 10000000000000000 00 00 00000000 00 0 0 ff 1
0 0 0 00 000 0 0 ffffffffffffffffffffffffffffffff 00 00 00000000 00 0 0 ff 0

// File: dv/tb_eflash_row_driver.sv
// testbench for the eflash row driver; replays vectors from the stim file and checks the registered drive

`timescale 1ns/1ps

module tb_eflash_row_driver;

    localparam int    MAX_RESET_CYCLES = 16;
    localparam int    MAX_LINES        = 400;   // bounds the vector loop
    localparam string STIM_FILE        = "dv/eflash_row_driver_stim.txt";

    logic                     clk_i;
    logic                     rst_ni;
    logic                     pim_en;
    eflash_pkg::pim_cmd_t     cmd;
    eflash_pkg::hvs_drive_t   hvs;
    eflash_pkg::array_drive_t arr;

    eflash_pkg::hvs_drive_t   exp_hvs;   // vector now sitting in the output register
    eflash_pkg::array_drive_t exp_arr;
    int                       exp_idx;

    eflash_row_driver dut0 (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .pim_en_i (pim_en),
        .cmd_i    (cmd),
        .hvs_o    (hvs),
        .array_o  (arr)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("FAIL %s expected %0h actual %0h", name, exp_v, act_v));
        end
    endtask

    task automatic check_outputs();
        string tag;
        tag = $sformatf("vector %0d", exp_idx);
        check_value({tag, " hvs mode"}, exp_hvs.mode, hvs.mode);
        check_value({tag, " wl_sel"}, exp_hvs.wl_sel, hvs.wl_sel);
        check_value({tag, " vpass_en"}, exp_hvs.vpass_en, hvs.vpass_en);
        check_value({tag, " duml"}, exp_arr.duml, arr.duml);
        check_value({tag, " csl"}, exp_arr.csl, arr.csl);
        check_value({tag, " bsel"}, exp_arr.bsel, arr.bsel);
        check_value({tag, " csel"}, exp_arr.csel, arr.csel);
        check_value({tag, " adc_en1"}, exp_arr.adc_en1, arr.adc_en1);
        check_value({tag, " adc_en2"}, exp_arr.adc_en2, arr.adc_en2);
        check_value({tag, " qdac"}, exp_arr.qdac, arr.qdac);
        check_value({tag, " rsel"}, exp_arr.rsel, arr.rsel);
    endtask

    initial begin : main
        int           fd;
        int           n;
        int           wait_cnt;
        int           line_cnt;
        int           vec_cnt;
        bit           pending;
        string        line;
        logic [31:0]  en_v, mode_v, cnt_v, row_v, col_v, hmode_v;
        logic [31:0]  duml_v, csl_v, bsel_v, csel_v, a1_v, a2_v, qdac_v, rsel_v;
        logic [127:0] wl_v, vp_v;

        pim_en = 1'b0;
        cmd = '0;
        pending = 1'b0;
        line_cnt = 0;
        vec_cnt = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run({"could not open the stimulus file ", STIM_FILE});
        end

        wait_cnt = 0;
        while (rst_ni !== 1'b1) begin
            if (wait_cnt == MAX_RESET_CYCLES) begin
                abort_run("timed out waiting for reset to be released");
            end
            @(posedge clk_i);
            wait_cnt++;
        end

        while (!$feof(fd)) begin
            line_cnt++;
            if (line_cnt > MAX_LINES) begin
                abort_run("timed out reading vectors, stimulus file is too long");
            end
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        en_v, mode_v, cnt_v, row_v, col_v, hmode_v, wl_v, vp_v,
                        duml_v, csl_v, bsel_v, csel_v, a1_v, a2_v, qdac_v, rsel_v);
            if (n != 16) begin
                abort_run($sformatf("stimulus line %0d does not hold 16 fields", line_cnt));
            end

            @(posedge clk_i);
            pim_en       <= en_v[0];
            cmd.mode     <= eflash_pkg::pim_mode_e'(mode_v[2:0]);
            cmd.exec_cnt <= cnt_v[3:0];
            cmd.row      <= row_v[6:0];
            cmd.col      <= col_v[8:0];

            @(negedge clk_i);
            if (pending) begin
                check_outputs();   // previous vector captured at this edge
            end

            exp_hvs.mode     = eflash_pkg::hvs_mode_e'(hmode_v[1:0]);
            exp_hvs.wl_sel   = wl_v;
            exp_hvs.vpass_en = vp_v;
            exp_arr.duml     = duml_v[7:0];
            exp_arr.csl      = csl_v[7:0];
            exp_arr.bsel     = bsel_v;
            exp_arr.csel     = csel_v[7:0];
            exp_arr.adc_en1  = a1_v[0];
            exp_arr.adc_en2  = a2_v[0];
            exp_arr.qdac     = qdac_v[7:0];
            exp_arr.rsel     = rsel_v[1:0];
            exp_idx = vec_cnt;
            pending = 1'b1;
            vec_cnt++;
        end
        $fclose(fd);

        // flush the last vector out of the register
        @(posedge clk_i);
        pim_en <= 1'b0;
        @(negedge clk_i);
        if (pending) begin
            check_outputs();
        end

        if (vec_cnt == 0) begin
            abort_run("the stimulus file held no vectors");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

// File: logic/array_sequencer.sv
// array-side sequencer; picks dummy, column, bit-line and sector selects plus sense controls per phase

`timescale 1ns/1ps

module array_sequencer (
    input  eflash_pkg::pim_cmd_t     cmd_i,
    output eflash_pkg::array_drive_t array_o
);

    logic [$clog2(eflash_pkg::NUM_BSEL_PHASES)-1:0] col_phase;
    logic [eflash_pkg::BSEL_W-1:0]                  col_pat;
    logic [eflash_pkg::NUM_SECTORS-1:0]             sec_onehot;

    assign col_phase = cmd_i.col[$clog2(eflash_pkg::NUM_BSEL_PHASES)-1:0];

    // bit (8*group + phase) for every group that lands on the 32-bit bus
    always_comb begin
        col_pat = '0;
        for (int g = 0; g < eflash_pkg::BSEL_W / eflash_pkg::BSEL_GROUPS; g++) begin
            col_pat[eflash_pkg::BSEL_GROUPS * g + col_phase] = 1'b1;
        end
    end

    always_comb begin
        sec_onehot = '0;
        sec_onehot[cmd_i.row.sector] = 1'b1;
    end

    always_comb begin
        array_o = eflash_pkg::ARRAY_IDLE;

        case (cmd_i.mode)
            eflash_pkg::PIM_ERASE: begin
                array_o.bsel = '1;          // whole sector erased
                array_o.csel = sec_onehot;
            end

            eflash_pkg::PIM_PROGRAM: begin
                array_o.csl  = '1;
                array_o.bsel = col_pat;
                array_o.csel = sec_onehot;
            end

            eflash_pkg::PIM_READ: begin
                array_o.rsel = 2'd1;
                case (cmd_i.exec_cnt) inside
                    [4'd5:4'd8]: begin      // precharge via dummy line
                        array_o.duml = sec_onehot;
                        array_o.bsel = col_pat;
                    end
                    [4'd3:4'd4]: begin
                        array_o.bsel = col_pat;
                    end
                    4'd2: begin
                        array_o.csel = sec_onehot;
                    end
                    [4'd0:4'd1]: begin      // sample
                        array_o.csel    = sec_onehot;
                        array_o.adc_en1 = 1'b1;
                    end
                    default: ;
                endcase
            end

            eflash_pkg::PIM_PARALLEL: begin
                array_o.rsel = 2'd2;
                case (cmd_i.exec_cnt) inside
                    [4'd6:4'd11]: begin
                        array_o.duml = '1;
                        array_o.bsel = col_pat;
                    end
                    [4'd0:4'd5]: begin
                        // all sectors sensed while the dac ramps from count 3 down
                        array_o.csel    = '1;
                        array_o.adc_en1 = cmd_i.exec_cnt inside {4'd3, 4'd4};
                        array_o.adc_en2 = cmd_i.exec_cnt <= 4'd1;
                        if (cmd_i.exec_cnt <= 4'd3) begin
                            array_o.qdac = '0;
                        end
                    end
                    default: ;
                endcase
            end

            default: ;
        endcase
    end

endmodule

// File: logic/eflash_pkg.sv
// shared geometry, command and drive types that every eflash row driver file refers to by scoped name

package eflash_pkg;

    // array geometry fixed by the analog macro
    localparam int NUM_ROWS        = 128;
    localparam int ROWS_PER_SECTOR = 16;
    localparam int NUM_SECTORS     = NUM_ROWS / ROWS_PER_SECTOR;  // 8
    localparam int NUM_BSEL_PHASES = 4;
    localparam int BSEL_GROUPS     = 8;
    localparam int BSEL_W          = NUM_BSEL_PHASES * BSEL_GROUPS;

    // row address with the sector on top
    typedef struct packed {
        logic [$clog2(NUM_SECTORS)-1:0]     sector;
        logic [$clog2(ROWS_PER_SECTOR)-1:0] line;
    } row_addr_t;

    typedef logic [8:0] col_addr_t;   // only the low bits (column phase) matter
    typedef logic [3:0] exec_cnt_t;   // counts down through an operation

    // 0 and 5..7 are not supported
    typedef enum logic [2:0] {
        PIM_ERASE    = 3'd1,
        PIM_PROGRAM  = 3'd2,
        PIM_READ     = 3'd3,
        PIM_PARALLEL = 3'd4
    } pim_mode_e;

    typedef struct packed {
        pim_mode_e mode;
        exec_cnt_t exec_cnt;
        row_addr_t row;
        col_addr_t col;
    } pim_cmd_t;

    // code sent to the high-voltage switch
    typedef enum logic [1:0] {
        HVS_ERASE   = 2'd0,
        HVS_PROGRAM = 2'd1,
        HVS_READ    = 2'd2
    } hvs_mode_e;

    typedef struct packed {
        hvs_mode_e           mode;
        logic [NUM_ROWS-1:0] wl_sel;
        logic [NUM_ROWS-1:0] vpass_en;
    } hvs_drive_t;

    typedef struct packed {
        logic [NUM_SECTORS-1:0] duml;   // dummy lines
        logic [NUM_SECTORS-1:0] csl;    // column lines
        logic [BSEL_W-1:0]      bsel;   // bit lines with phases interleaved
        logic [NUM_SECTORS-1:0] csel;   // sector select
        logic                   adc_en1;
        logic                   adc_en2;
        logic [7:0]             qdac;   // charge dac code held at ff when unused
        logic [1:0]             rsel;   // 1 single read, 2 parallel
    } array_drive_t;

    // idle has no word line selected and all pass gates on
    localparam hvs_drive_t HVS_IDLE = '{
        mode:     HVS_ERASE,
        wl_sel:   '0,
        vpass_en: '1
    };

    localparam array_drive_t ARRAY_IDLE = '{
        qdac:    8'hFF,
        default: '0
    };

endpackage

// File: logic/eflash_row_driver.sv
// top of the eflash row driver; one command in per cycle, registered drive out one cycle later

`timescale 1ns/1ps

module eflash_row_driver (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     pim_en_i,
    input  eflash_pkg::pim_cmd_t     cmd_i,
    output eflash_pkg::hvs_drive_t   hvs_o,
    output eflash_pkg::array_drive_t array_o
);

    eflash_pkg::hvs_drive_t   hvs_next;
    eflash_pkg::array_drive_t array_next;

    // word lines and array side decode in parallel
    wl_decoder u_wl_decoder (
        .cmd_i (cmd_i),
        .hvs_o (hvs_next)
    );

    array_sequencer u_array_sequencer (
        .cmd_i   (cmd_i),
        .array_o (array_next)
    );

    row_drive_merge u_row_drive_merge (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .pim_en_i (pim_en_i),
        .mode_i   (cmd_i.mode),
        .hvs_i    (hvs_next),
        .array_i  (array_next),
        .hvs_o    (hvs_o),
        .array_o  (array_o)
    );

endmodule

// File: logic/row_drive_merge.sv
// output stage; masks inactive commands to idle and registers both drive groups for one cycle

`timescale 1ns/1ps

module row_drive_merge (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     pim_en_i,
    input  eflash_pkg::pim_mode_e    mode_i,
    input  eflash_pkg::hvs_drive_t   hvs_i,
    input  eflash_pkg::array_drive_t array_i,
    output eflash_pkg::hvs_drive_t   hvs_o,
    output eflash_pkg::array_drive_t array_o
);

    logic                     active;
    eflash_pkg::hvs_drive_t   hvs_d;
    eflash_pkg::array_drive_t array_d;

    // unsupported codes behave like a disabled driver
    assign active = pim_en_i && (mode_i inside {
        eflash_pkg::PIM_ERASE,
        eflash_pkg::PIM_PROGRAM,
        eflash_pkg::PIM_READ,
        eflash_pkg::PIM_PARALLEL
    });

    assign hvs_d   = active ? hvs_i   : eflash_pkg::HVS_IDLE;
    assign array_d = active ? array_i : eflash_pkg::ARRAY_IDLE;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hvs_o   <= eflash_pkg::HVS_IDLE;     // pass gates on, adcs off
            array_o <= eflash_pkg::ARRAY_IDLE;
        end else begin
            hvs_o   <= hvs_d;
            array_o <= array_d;
        end
    end

endmodule

// File: logic/wl_decoder.sv
// combinational word-line decoder that turns command mode and row into the high-voltage switch drive

`timescale 1ns/1ps

module wl_decoder (
    input  eflash_pkg::pim_cmd_t   cmd_i,
    output eflash_pkg::hvs_drive_t hvs_o
);

    logic [eflash_pkg::NUM_ROWS-1:0] row_onehot;
    logic [eflash_pkg::NUM_ROWS-1:0] row_stripe;  // same line in every sector

    always_comb begin
        row_onehot = '0;
        row_onehot[cmd_i.row] = 1'b1;

        row_stripe = '0;
        for (int s = 0; s < eflash_pkg::NUM_SECTORS; s++) begin
            row_stripe[s * eflash_pkg::ROWS_PER_SECTOR + cmd_i.row.line] = 1'b1;
        end
    end

    always_comb begin
        hvs_o = eflash_pkg::HVS_IDLE;

        case (cmd_i.mode)
            eflash_pkg::PIM_ERASE: begin
                hvs_o.mode   = eflash_pkg::HVS_ERASE;
                hvs_o.wl_sel = row_onehot;  // pass gates stay all on
            end
            eflash_pkg::PIM_PROGRAM: begin
                hvs_o.mode     = eflash_pkg::HVS_PROGRAM;
                hvs_o.wl_sel   = row_onehot;
                hvs_o.vpass_en = row_onehot;
            end
            eflash_pkg::PIM_READ: begin
                hvs_o.mode     = eflash_pkg::HVS_READ;
                hvs_o.wl_sel   = row_onehot;
                hvs_o.vpass_en = row_onehot;
            end
            eflash_pkg::PIM_PARALLEL: begin
                // one word line per sector read together
                hvs_o.mode     = eflash_pkg::HVS_READ;
                hvs_o.wl_sel   = row_stripe;
                hvs_o.vpass_en = row_stripe;
            end
            default: ;
        endcase
    end

endmodule
